//--- Makefile
# Verilator build and run for the gpu_line core
VERILATOR ?= verilator
TOP       ?= gpu_tb
FILELIST  ?= gpu_line.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTS PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- gpu_line.f
verilog/gpu_pkg.sv
verilog/gpu_ifs.sv
verilog/cmd_decode.sv
verilog/line_engine.sv
verilog/pixel_writer.sv
verilog/gpu_top.sv
verif/gpu_checker.sv
verif/gpu_tb.sv

//--- verif/gpu_checker.sv
`timescale 1ns/1ps

module gpu_checker (
	input logic               clk,
	input logic               rst_n,
	input logic               cmd_req,
	input logic               cmd_ack,
	input logic               pix_valid,
	input logic               pix_ready,
	input gpu_pkg::pix_addr_t pix_addr,
	input gpu_pkg::color_t    pix_data
);

	// four-phase command handshake
	a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cmd_ack) |-> cmd_req)
		else $error("cmd_ack rose without cmd_req");

	a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(cmd_ack) |-> !$past(cmd_req))
		else $error("cmd_ack fell before cmd_req dropped");

	// write port holds under back-pressure
	a_pix_hold: assert property (@(posedge clk) disable iff (!rst_n)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix_addr) && $stable(pix_data))
		else $error("pixel write changed while stalled");

	a_pix_reset: assert property (@(posedge clk) !rst_n |=> !pix_valid)
		else $error("pix_valid high during reset");

endmodule

bind gpu_top gpu_checker u_checker (
	.clk       (clk),
	.rst_n     (rst_n),
	.cmd_req   (cmd_req),
	.cmd_ack   (cmd_ack),
	.pix_valid (pix_valid),
	.pix_ready (pix_ready),
	.pix_addr  (pix_addr),
	.pix_data  (pix_data)
);

//--- verif/gpu_tb.sv
`timescale 1ns/1ps

module gpu_tb;

	localparam int XRES = 24;
	localparam int YRES = 16;

	logic               clk;
	logic               rst_n;
	logic               cmd_req;
	gpu_pkg::cmd_word_t cmd_data;
	logic               cmd_ack;
	logic               pix_valid;
	gpu_pkg::pix_addr_t pix_addr;
	gpu_pkg::color_t    pix_data;
	logic               pix_ready;

	// reference model state and expected writes
	gpu_pkg::coord_x_t  m_sx, m_ex;
	gpu_pkg::coord_y_t  m_sy, m_ey;
	gpu_pkg::color_t    m_col;
	logic               m_bsel;
	gpu_pkg::pix_addr_t exp_addr[$];
	gpu_pkg::color_t    exp_col[$];
	int                 n_steps;
	int                 n_cmds;
	int                 cycles;

	gpu_top #(.XRES(XRES), .YRES(YRES)) UUT (
		.clk(clk), .rst_n(rst_n), .cmd_req(cmd_req), .cmd_data(cmd_data),
		.cmd_ack(cmd_ack), .pix_valid(pix_valid), .pix_addr(pix_addr),
		.pix_data(pix_data), .pix_ready(pix_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_addr(input gpu_pkg::pix_addr_t exp, input gpu_pkg::pix_addr_t act);
		if (exp !== act)
			abort_run($sformatf("Fail at %0t: address expected %0d, got %0d", $time, exp, act));
	endtask

	task automatic check_color(input gpu_pkg::color_t exp, input gpu_pkg::color_t act);
		if (exp !== act)
			abort_run($sformatf("Fail at %0t: colour expected %06h, got %06h", $time, exp, act));
	endtask

	// one rasterised point, clipped to the frame
	function automatic void push_pixel(input int x, input int y);
		n_steps++;
		if (x < XRES && y < YRES)
		begin
			exp_addr.push_back(m_bsel * XRES * YRES + y * XRES + x);
			exp_col.push_back(m_col);
		end
	endfunction

	function automatic void ref_line(input gpu_pkg::cmd_word_t w);
		int            px, py, dx, dy, stx, sty, e2;
		gpu_pkg::err_t err;
		bit            done;
		n_cmds++;
		case (gpu_pkg::opcode_t'(w[26:24]))
			gpu_pkg::op_set_start: {m_sx, m_sy} = w[16:0];
			gpu_pkg::op_set_end:   {m_ex, m_ey} = w[16:0];
			gpu_pkg::op_set_color: m_col = w[23:0];
			gpu_pkg::op_move_start:
			begin
				m_sx = m_sx + w[16:8];
				m_sy = m_sy + w[7:0];
			end
			gpu_pkg::op_move_end:
			begin
				m_ex = m_ex + w[16:8];
				m_ey = m_ey + w[7:0];
			end
			gpu_pkg::op_flip: m_bsel = !m_bsel;
			gpu_pkg::op_clear:
				for (int y = 0; y < YRES; y++)
					for (int x = 0; x < XRES; x++)
						push_pixel(x, y);
			default:
			begin
				px = m_sx;
				py = m_sy;
				dx = (m_ex >= m_sx) ? int'(m_ex) - px : px - int'(m_ex);
				dy = (m_ey >= m_sy) ? py - int'(m_ey) : int'(m_ey) - py;
				stx = (m_ex >= m_sx) ? 1 : -1;
				sty = (m_ey >= m_sy) ? 1 : -1;
				err = gpu_pkg::err_t'(dx + dy);
				done = 1'b0;
				while (!done)
				begin
					push_pixel(px, py);
					if (px == int'(m_ex) && py == int'(m_ey))
						done = 1'b1;
					else
					begin
						e2 = 2 * int'(err);
						if (e2 >= dy)
						begin
							err = gpu_pkg::err_t'(int'(err) + dy);
							px = px + stx;
						end
						if (e2 <= dx)
						begin
							err = gpu_pkg::err_t'(int'(err) + dx);
							py = py + sty;
						end
					end
				end
			end
		endcase
	endfunction

	task automatic send_cmd(input gpu_pkg::opcode_t op, input logic [23:0] arg);
		gpu_pkg::cmd_word_t w;
		w = {5'b0, op, arg};
		@(posedge clk);
		cmd_req  <= 1'b1;
		cmd_data <= w;
		do @(posedge clk); while (!cmd_ack);
		// an earlier job may leave only its last write in the output register
		if (exp_addr.size() > 1)
			abort_run($sformatf("Command acknowledged at %0t while %0d writes %s",
				$time, exp_addr.size(), "of an earlier job were still pending"));
		ref_line(w);
		cmd_req <= 1'b0;
		do @(posedge clk); while (cmd_ack);
	endtask

	task automatic set_start(input int x, input int y);
		send_cmd(gpu_pkg::op_set_start, {7'b0, 9'(x), 8'(y)});
	endtask

	task automatic set_end(input int x, input int y);
		send_cmd(gpu_pkg::op_set_end, {7'b0, 9'(x), 8'(y)});
	endtask

	task automatic move_start(input int x, input int y);
		send_cmd(gpu_pkg::op_move_start, {7'b0, 9'(x), 8'(y)});
	endtask

	task automatic move_end(input int x, input int y);
		send_cmd(gpu_pkg::op_move_end, {7'b0, 9'(x), 8'(y)});
	endtask

	task automatic set_color(input gpu_pkg::color_t c);
		send_cmd(gpu_pkg::op_set_color, c);
	endtask

	task automatic draw();
		send_cmd(gpu_pkg::op_draw, 24'h0);
	endtask

	task automatic clear();
		send_cmd(gpu_pkg::op_clear, 24'h0);
	endtask

	task automatic flip();
		send_cmd(gpu_pkg::op_flip, 24'h0);
	endtask

	// memory side, ready about 70 percent of cycles
	always @(posedge clk)
		pix_ready <= ($urandom % 100) < 70;

	// compare each accepted write against the model queue
	always @(posedge clk)
	begin
		if (rst_n && pix_valid && pix_ready)
		begin
			if (exp_addr.size() == 0)
				abort_run($sformatf("Fail at %0t: unexpected write to %0d", $time, pix_addr));
			else
			begin
				check_addr(exp_addr.pop_front(), pix_addr);
				check_color(exp_col.pop_front(), pix_data);
			end
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > 4 * n_steps + 40 * (n_cmds + 1))
			abort_run("Timeout: the run did not finish within its cycle limit");
	end

	initial
	begin
		int ox[11];
		int oy[11];
		ox = '{20, 14, 10, 4, 4, 10, 14, 20, 3, 23, 5};
		oy = '{11, 15, 15, 11, 5, 1, 1, 5, 3, 0, 15};
		void'($urandom(32'h20cf_7e2e));
		cycles = 0;
		n_steps = 0;
		n_cmds = 0;
		m_bsel = 1'b0;
		cmd_req = 1'b0;
		cmd_data = '0;
		pix_ready = 1'b0;
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// eight octants from the centre, then point, horizontal, vertical
		set_color(24'hff8040);
		for (int i = 0; i < 11; i++)
		begin
			if (i < 8)
				set_start(12, 8);
			else
				set_start(i == 8 ? 3 : (i == 9 ? 0 : 5), i == 8 ? 3 : 0);
			set_end(ox[i], oy[i]);
			draw();
		end

		// move with wrap at 9 and 8 bits
		set_color(24'h00ff00);
		set_start(2, 3);
		set_end(6, 4);
		move_start(510, 1);
		move_end(3, 254);
		draw();

		clear();
		flip();
		set_color(24'h123456);
		clear();
		set_start(1, 1);
		set_end(22, 14);
		draw();
		flip();

		// partly off-frame lines
		set_start(20, 12);
		set_end(30, 20);
		draw();
		set_start(30, 3);
		set_end(10, 3);
		draw();

		// random lines with commands queued behind each draw
		for (int i = 0; i < 12; i++)
		begin
			set_color(gpu_pkg::color_t'($urandom));
			set_start($urandom % 32, $urandom % 20);
			set_end($urandom % 32, $urandom % 20);
			draw();
		end

		while (exp_addr.size() != 0)
			@(posedge clk);
		repeat (10) @(posedge clk);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- verilog/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              cmd_req,
	input  gpu_pkg::cmd_word_t cmd_data,
	output logic              cmd_ack,
	draw_if.src               draw
);

	gpu_pkg::opcode_t  op;
	gpu_pkg::coord_x_t arg_x;
	gpu_pkg::coord_y_t arg_y;
	gpu_pkg::color_t   arg_color;
	logic              take;

	gpu_pkg::coord_x_t start_x;
	gpu_pkg::coord_y_t start_y;
	gpu_pkg::coord_x_t end_x;
	gpu_pkg::coord_y_t end_y;
	gpu_pkg::color_t   color_q;
	logic              back_sel_q;

	// field extraction
	assign op        = gpu_pkg::opcode_t'(cmd_data[26:24]);
	assign arg_x     = cmd_data[16:8];
	assign arg_y     = cmd_data[7:0];
	assign arg_color = cmd_data[23:0];

	// new request, engine free
	assign take = cmd_req && !cmd_ack && !draw.busy;

	// handshake, flip and start pulses
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cmd_ack         <= 1'b0;
			back_sel_q      <= 1'b0;
			draw.start_line <= 1'b0;
			draw.start_fill <= 1'b0;
		end
		else
		begin
			draw.start_line <= 1'b0;
			draw.start_fill <= 1'b0;
			if (!cmd_req)
				cmd_ack <= 1'b0;
			else if (take)
			begin
				cmd_ack <= 1'b1;
				case (op)
					gpu_pkg::op_draw:  draw.start_line <= 1'b1;
					gpu_pkg::op_clear: draw.start_fill <= 1'b1;
					gpu_pkg::op_flip:  back_sel_q <= !back_sel_q;
					default:           ;
				endcase
			end
		end
	end

	// point and colour registers
	// move sums wrap at the field width
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			case (op)
				gpu_pkg::op_set_start:
				begin
					start_x <= arg_x;
					start_y <= arg_y;
				end
				gpu_pkg::op_set_end:
				begin
					end_x <= arg_x;
					end_y <= arg_y;
				end
				gpu_pkg::op_set_color:  color_q <= arg_color;
				gpu_pkg::op_move_start:
				begin
					start_x <= start_x + arg_x;
					start_y <= start_y + arg_y;
				end
				gpu_pkg::op_move_end:
				begin
					end_x <= end_x + arg_x;
					end_y <= end_y + arg_y;
				end
				default: ;
			endcase
		end
	end

	assign draw.x0       = start_x;
	assign draw.y0       = start_y;
	assign draw.x1       = end_x;
	assign draw.y1       = end_y;
	assign draw.color    = color_q;
	assign draw.back_sel = back_sel_q;

endmodule

//--- verilog/gpu_ifs.sv
`timescale 1ns/1ps

// drawing job from the command decoder to the rasteriser
interface draw_if;
	gpu_pkg::coord_x_t x0;
	gpu_pkg::coord_y_t y0;
	gpu_pkg::coord_x_t x1;
	gpu_pkg::coord_y_t y1;
	gpu_pkg::color_t   color;
	logic              back_sel;
	logic              start_line;
	logic              start_fill;
	logic              busy;

	modport src (
		output x0, y0, x1, y1, color, back_sel, start_line, start_fill,
		input  busy
	);

	modport dst (
		input  x0, y0, x1, y1, color, back_sel, start_line, start_fill,
		output busy
	);
endinterface

// pixel stream, valid/ready
interface pix_if;
	gpu_pkg::coord_x_t x;
	gpu_pkg::coord_y_t y;
	gpu_pkg::color_t   color;
	logic              back_sel;
	logic              valid;
	logic              ready;

	modport src (
		output x, y, color, back_sel, valid,
		input  ready
	);

	modport dst (
		input  x, y, color, back_sel, valid,
		output ready
	);
endinterface

//--- verilog/gpu_pkg.sv
package gpu_pkg;

	// pixel coordinates, x up to 511, y up to 255
	typedef logic [8:0] coord_x_t;
	typedef logic [7:0] coord_y_t;

	// rgb, red in the top byte
	typedef logic [23:0] color_t;

	// word address into the frame memory
	typedef logic [31:0] pix_addr_t;

	// host command word
	// opcode in [26:24], colour in [23:0], point x in [16:8], y in [7:0]
	typedef logic [31:0] cmd_word_t;

	// bresenham error term
	typedef logic signed [10:0] err_t;

	typedef enum logic [2:0] {
		op_clear      = 3'd0,
		op_set_start  = 3'd1,
		op_set_end    = 3'd2,
		op_set_color  = 3'd3,
		op_move_start = 3'd4,
		op_move_end   = 3'd5,
		op_draw       = 3'd6,
		op_flip       = 3'd7
	} opcode_t;

	typedef enum logic [1:0] {
		st_idle,
		st_line,
		st_fill
	} engine_state_t;

endpackage

//--- verilog/gpu_top.sv
`timescale 1ns/1ps

module gpu_top #(
	parameter int XRES = 320,
	parameter int YRES = 240
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cmd_req,
	input  gpu_pkg::cmd_word_t  cmd_data,
	output logic                cmd_ack,
	output logic                pix_valid,
	output gpu_pkg::pix_addr_t  pix_addr,
	output gpu_pkg::color_t     pix_data,
	input  logic                pix_ready
);

	draw_if draw_bus();
	pix_if  pix_bus();

	cmd_decode u_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.cmd_req  (cmd_req),
		.cmd_data (cmd_data),
		.cmd_ack  (cmd_ack),
		.draw     (draw_bus.src)
	);

	line_engine #(
		.XRES (XRES),
		.YRES (YRES)
	) u_engine (
		.clk   (clk),
		.rst_n (rst_n),
		.draw  (draw_bus.dst),
		.pix   (pix_bus.src)
	);

	pixel_writer #(
		.XRES (XRES),
		.YRES (YRES)
	) u_writer (
		.clk       (clk),
		.rst_n     (rst_n),
		.pix       (pix_bus.dst),
		.pix_valid (pix_valid),
		.pix_addr  (pix_addr),
		.pix_data  (pix_data),
		.pix_ready (pix_ready)
	);

endmodule

//--- verilog/line_engine.sv
`timescale 1ns/1ps

module line_engine #(
	parameter int XRES = 320,
	parameter int YRES = 240
) (
	input  logic clk,
	input  logic rst_n,
	draw_if.dst  draw,
	pix_if.src   pix
);

	gpu_pkg::engine_state_t state;

	gpu_pkg::coord_x_t cur_x;
	gpu_pkg::coord_y_t cur_y;
	gpu_pkg::coord_x_t end_x;
	gpu_pkg::coord_y_t end_y;
	gpu_pkg::color_t   color_q;
	logic              back_sel_q;
	gpu_pkg::err_t     dx;
	gpu_pkg::err_t     dy;
	gpu_pkg::err_t     err;
	logic              x_neg;
	logic              y_neg;

	gpu_pkg::err_t     ld_dx;
	gpu_pkg::err_t     ld_dy;
	gpu_pkg::err_t     err_nxt;
	logic signed [11:0] e2;
	logic              step_x;
	logic              step_y;
	logic              fire;
	logic              line_done;
	logic              fill_done;
	logic              row_end;

	// initial deltas from the job, dy kept negative
	assign ld_dx = (draw.x1 >= draw.x0) ? gpu_pkg::err_t'(draw.x1 - draw.x0)
	                                    : gpu_pkg::err_t'(draw.x0 - draw.x1);
	assign ld_dy = (draw.y1 >= draw.y0) ? -gpu_pkg::err_t'(draw.y1 - draw.y0)
	                                    : -gpu_pkg::err_t'(draw.y0 - draw.y1);

	// e2 can reach about 3*dx, one bit wider than err
	assign e2     = $signed({err, 1'b0});
	assign step_x = (e2 >= dy);
	assign step_y = (e2 <= dx);

	always_comb
	begin
		err_nxt = err;
		if (step_x)
			err_nxt = err_nxt + dy;
		if (step_y)
			err_nxt = err_nxt + dx;
	end

	assign fire      = pix.valid && pix.ready;
	assign line_done = (cur_x == end_x) && (cur_y == end_y);
	assign row_end   = (cur_x == gpu_pkg::coord_x_t'(XRES - 1));
	assign fill_done = row_end && (cur_y == gpu_pkg::coord_y_t'(YRES - 1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= gpu_pkg::st_idle;
		else
		begin
			case (state)
				gpu_pkg::st_idle:
					if (draw.start_line)
						state <= gpu_pkg::st_line;
					else if (draw.start_fill)
						state <= gpu_pkg::st_fill;
				gpu_pkg::st_line:
					if (fire && line_done)
						state <= gpu_pkg::st_idle;
				gpu_pkg::st_fill:
					if (fire && fill_done)
						state <= gpu_pkg::st_idle;
				default: state <= gpu_pkg::st_idle;
			endcase
		end
	end

	// walk registers, loaded on a start pulse and stepped per accepted pixel
	always_ff @(posedge clk)
	begin
		if (state == gpu_pkg::st_idle)
		begin
			color_q    <= draw.color;
			back_sel_q <= draw.back_sel;
			if (draw.start_line)
			begin
				cur_x <= draw.x0;
				cur_y <= draw.y0;
				end_x <= draw.x1;
				end_y <= draw.y1;
				dx    <= ld_dx;
				dy    <= ld_dy;
				err   <= ld_dx + ld_dy;
				x_neg <= (draw.x1 < draw.x0);
				y_neg <= (draw.y1 < draw.y0);
			end
			else
			begin
				cur_x <= '0;
				cur_y <= '0;
			end
		end
		else if (fire && state == gpu_pkg::st_line)
		begin
			err <= err_nxt;
			if (step_x)
				cur_x <= x_neg ? cur_x - 1'b1 : cur_x + 1'b1;
			if (step_y)
				cur_y <= y_neg ? cur_y - 1'b1 : cur_y + 1'b1;
		end
		else if (fire)
		begin
			// fill, row-major
			if (row_end)
			begin
				cur_x <= '0;
				cur_y <= cur_y + 1'b1;
			end
			else
				cur_x <= cur_x + 1'b1;
		end
	end

	assign pix.valid    = (state != gpu_pkg::st_idle);
	assign pix.x        = cur_x;
	assign pix.y        = cur_y;
	assign pix.color    = color_q;
	assign pix.back_sel = back_sel_q;
	assign draw.busy    = (state != gpu_pkg::st_idle);

endmodule

//--- verilog/pixel_writer.sv
`timescale 1ns/1ps

module pixel_writer #(
	parameter int XRES = 320,
	parameter int YRES = 240
) (
	input  logic                clk,
	input  logic                rst_n,
	pix_if.dst                  pix,
	output logic                pix_valid,
	output gpu_pkg::pix_addr_t  pix_addr,
	output gpu_pkg::color_t     pix_data,
	input  logic                pix_ready
);

	logic               in_ready;
	logic               in_frame;
	logic               accept;
	gpu_pkg::pix_addr_t base;
	gpu_pkg::pix_addr_t addr;

	// output slot free or draining this cycle
	assign in_ready  = !pix_valid || pix_ready;
	assign pix.ready = in_ready;
	assign accept    = pix.valid && in_ready;

	assign in_frame = (32'(pix.x) < XRES) && (32'(pix.y) < YRES);

	// back buffer sits directly above the front one
	assign base = pix.back_sel ? gpu_pkg::pix_addr_t'(XRES * YRES) : '0;
	assign addr = base + gpu_pkg::pix_addr_t'(pix.y) * gpu_pkg::pix_addr_t'(XRES)
	            + gpu_pkg::pix_addr_t'(pix.x);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pix_valid <= 1'b0;
		else if (in_ready)
			pix_valid <= pix.valid && in_frame;
	end

	// clipped pixels are taken but never loaded
	always_ff @(posedge clk)
	begin
		if (accept && in_frame)
		begin
			pix_addr <= addr;
			pix_data <= pix.color;
		end
	end

endmodule
